//--- design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;      // pipeline data word
    typedef logic [4:0]  reg_addr_t;  // register number

    // load/store access size, encoded as in the execute stage
    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } mem_width_e;

    // execute to memory bundle
    typedef struct packed {
        word_t      result;      // alu result, also byte address
        word_t      store_data;
        reg_addr_t  reg2write;
        mem_width_e width;
        logic       sign;        // 1 = sign extend loads
        logic       mem_write;
        logic       mem_read;
        logic       mem2reg;
        logic       reg_write;
    } ex_mem_t;

    // memory to write-back bundle
    typedef struct packed {
        word_t      read_data;
        word_t      alu_result;
        reg_addr_t  reg2write;
        logic       mem2reg;     // 1 = write back loaded data
        logic       reg_write;
    } mem_wb_t;

endpackage

//--- design/axil_pkg.sv
package axil_pkg;

    typedef logic [11:0] axil_addr_t;  // debug byte address
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    // 0 selects data memory, 1 selects register file (0x800 + 4*n)
    localparam int dbg_reg_region_bit = 11;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                        clk,
    // pipeline port, byte lanes
    input  logic [$clog2(RAM_DEPTH)-1:0] i_a_addr,
    input  logic [3:0]                  i_a_byte_en,
    input  mips_pkg::word_t             i_a_wdata,
    output mips_pkg::word_t             o_a_rdata,
    // debug port, whole words
    input  logic [$clog2(RAM_DEPTH)-1:0] i_b_addr,
    input  logic                        i_b_we,
    input  mips_pkg::word_t             i_b_wdata,
    output mips_pkg::word_t             o_b_rdata
);

    mips_pkg::word_t mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (i_a_byte_en[i]) begin
                mem[i_a_addr][8*i +: 8] <= i_a_wdata[8*i +: 8];
            end
        end
        if (i_b_we) begin
            mem[i_b_addr] <= i_b_wdata;
        end
    end

    assign o_a_rdata = mem[i_a_addr];  // async read
    assign o_b_rdata = mem[i_b_addr];

    // debug writes only happen halted, pipeline stores only running
    a_port_excl: assert property (@(posedge clk) !((|i_a_byte_en) && i_b_we))
        else $error("data_ram: both ports write in one cycle");

endmodule

//--- design/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  mips_pkg::mem_width_e i_width,
    input  logic                 i_sign,
    input  logic [1:0]           i_byte_addr,   // low address bits
    input  mips_pkg::word_t      i_store_data,
    input  mips_pkg::word_t      i_ram_rdata,
    output logic [3:0]           o_byte_en,
    output mips_pkg::word_t      o_ram_wdata,
    output mips_pkg::word_t      o_load_data
);

    mips_pkg::word_t lane;  // addressed lane moved down to bit 0

    // store side
    always_comb begin
        o_byte_en   = 4'b0000;
        o_ram_wdata = i_store_data;
        case (i_width)
            mips_pkg::width_byte: begin
                o_ram_wdata = {4{i_store_data[7:0]}};
                o_byte_en   = 4'b0001 << i_byte_addr;
            end
            mips_pkg::width_half: begin
                o_ram_wdata = {2{i_store_data[15:0]}};
                o_byte_en   = i_byte_addr[1] ? 4'b1100 : 4'b0011;
            end
            mips_pkg::width_word: begin
                o_byte_en   = 4'b1111;
            end
            default: begin
                o_byte_en   = 4'b0000;  // unknown width writes nothing
            end
        endcase
    end

    assign lane = i_ram_rdata >> {i_byte_addr, 3'b000};

    // load side, sign set means extend with the lane's top bit
    always_comb begin
        case (i_width)
            mips_pkg::width_byte: begin
                o_load_data = {{24{i_sign & lane[7]}}, lane[7:0]};
            end
            mips_pkg::width_half: begin
                o_load_data = {{16{i_sign & lane[15]}}, lane[15:0]};
            end
            mips_pkg::width_word: begin
                o_load_data = lane;
            end
            default: begin
                o_load_data = i_ram_rdata;
            end
        endcase
    end

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_halt,
    input  mips_pkg::ex_mem_t            i_ex_mem,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_dbg_mem_addr,
    input  mips_pkg::word_t              i_dbg_mem_wdata,
    input  logic                         i_dbg_mem_we,
    output mips_pkg::word_t              o_dbg_mem_rdata,
    output mips_pkg::mem_wb_t            o_mem_wb
);

    localparam int AW = $clog2(RAM_DEPTH);

    logic [AW-1:0]     word_addr;
    logic [3:0]        lane_en;
    logic [3:0]        byte_en;
    mips_pkg::word_t   ram_wdata;
    mips_pkg::word_t   ram_rdata;
    mips_pkg::word_t   load_data;
    mips_pkg::mem_wb_t mem_wb_q;

    assign word_addr = i_ex_mem.result[AW+1:2];
    assign byte_en   = (i_ex_mem.mem_write && !i_halt) ? lane_en : 4'b0000;  // store blocked halted

    mem_access u_mem_access (
        .i_width      (i_ex_mem.width),
        .i_sign       (i_ex_mem.sign),
        .i_byte_addr  (i_ex_mem.result[1:0]),
        .i_store_data (i_ex_mem.store_data),
        .i_ram_rdata  (ram_rdata),
        .o_byte_en    (lane_en),
        .o_ram_wdata  (ram_wdata),
        .o_load_data  (load_data)
    );

    data_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_data_ram (
        .clk         (clk),
        .i_a_addr    (word_addr),
        .i_a_byte_en (byte_en),
        .i_a_wdata   (ram_wdata),
        .o_a_rdata   (ram_rdata),
        .i_b_addr    (i_dbg_mem_addr),
        .i_b_we      (i_dbg_mem_we),
        .i_b_wdata   (i_dbg_mem_wdata),
        .o_b_rdata   (o_dbg_mem_rdata)
    );

    // MEM/WB register, frozen while halted
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_wb_q <= '0;
        end else if (!i_halt) begin
            mem_wb_q.read_data  <= load_data;
            mem_wb_q.alu_result <= i_ex_mem.result;
            mem_wb_q.reg2write  <= i_ex_mem.reg2write;
            mem_wb_q.mem2reg    <= i_ex_mem.mem2reg;
            mem_wb_q.reg_write  <= i_ex_mem.reg_write;
        end
    end

    assign o_mem_wb = mem_wb_q;

    a_rw_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_ex_mem.mem_read && i_ex_mem.mem_write))
        else $error("mem_stage: load and store in one bundle");

    // half needs bit 0 clear, word needs both low bits clear
    a_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        (!i_halt && (i_ex_mem.mem_read || i_ex_mem.mem_write)) |->
        ((i_ex_mem.width != mips_pkg::width_half || !i_ex_mem.result[0]) &&
         (i_ex_mem.width != mips_pkg::width_word || i_ex_mem.result[1:0] == 2'b00)))
        else $error("mem_stage: misaligned access at %h", i_ex_mem.result);

endmodule

//--- design/reg_file_wb.sv
`timescale 1ns/1ps

module reg_file_wb (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_halt,
    input  mips_pkg::mem_wb_t    i_mem_wb,
    input  mips_pkg::reg_addr_t  i_dbg_reg_addr,
    input  mips_pkg::word_t      i_dbg_reg_wdata,
    input  logic                 i_dbg_reg_we,
    output mips_pkg::word_t      o_dbg_reg_rdata
);

    mips_pkg::word_t regs [32];
    mips_pkg::word_t wb_data;
    logic            wb_we;

    // write-back select
    assign wb_data = i_mem_wb.mem2reg ? i_mem_wb.read_data : i_mem_wb.alu_result;
    assign wb_we   = i_mem_wb.reg_write && !i_halt && (i_mem_wb.reg2write != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[i_mem_wb.reg2write] <= wb_data;
        end else if (i_dbg_reg_we && i_dbg_reg_addr != '0) begin
            regs[i_dbg_reg_addr] <= i_dbg_reg_wdata;  // debug only runs halted
        end
    end

    // r0 always reads zero
    assign o_dbg_reg_rdata = (i_dbg_reg_addr == '0) ? '0 : regs[i_dbg_reg_addr];

endmodule

//--- design/axil_debug_port.sv
`timescale 1ns/1ps

module axil_debug_port #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_halt,
    input  axil_pkg::axil_req_t          i_req,
    output axil_pkg::axil_rsp_t          o_rsp,
    output logic [$clog2(RAM_DEPTH)-1:0] o_dbg_mem_addr,
    output mips_pkg::word_t              o_dbg_mem_wdata,
    output logic                         o_dbg_mem_we,
    input  mips_pkg::word_t              i_dbg_mem_rdata,
    output mips_pkg::reg_addr_t          o_dbg_reg_addr,
    output mips_pkg::word_t              o_dbg_reg_wdata,
    output logic                         o_dbg_reg_we,
    input  mips_pkg::word_t              i_dbg_reg_rdata
);

    localparam int AW = $clog2(RAM_DEPTH);

    typedef enum logic [1:0] {
        st_idle,
        st_wr_resp,
        st_rd_resp
    } state_e;

    state_e               state;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 wr_ok;
    logic                 is_reg;
    axil_pkg::axil_addr_t sel_addr;
    axil_pkg::axil_resp_t bresp_q;
    axil_pkg::axil_resp_t rresp_q;
    axil_pkg::axil_data_t rdata_q;

    // write wins when both arrive together
    assign wr_fire  = (state == st_idle) && i_req.awvalid && i_req.wvalid;
    assign rd_fire  = (state == st_idle) && !(i_req.awvalid && i_req.wvalid) && i_req.arvalid;
    assign sel_addr = wr_fire ? i_req.awaddr : i_req.araddr;
    assign is_reg   = sel_addr[axil_pkg::dbg_reg_region_bit];
    assign wr_ok    = i_halt && (i_req.wstrb == 4'hf);  // full word writes only

    assign o_dbg_mem_addr  = sel_addr[AW+1:2];
    assign o_dbg_reg_addr  = sel_addr[6:2];
    assign o_dbg_mem_wdata = i_req.wdata;
    assign o_dbg_reg_wdata = i_req.wdata;
    assign o_dbg_mem_we    = wr_fire && wr_ok && !is_reg;
    assign o_dbg_reg_we    = wr_fire && wr_ok && is_reg;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= st_idle;
            bresp_q <= axil_pkg::resp_okay;
            rresp_q <= axil_pkg::resp_okay;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_fire) begin
                        state   <= st_wr_resp;
                        bresp_q <= wr_ok ? axil_pkg::resp_okay : axil_pkg::resp_slverr;
                    end else if (rd_fire) begin
                        state   <= st_rd_resp;
                        rresp_q <= i_halt ? axil_pkg::resp_okay : axil_pkg::resp_slverr;
                    end
                end
                st_wr_resp: if (i_req.bready) state <= st_idle;
                st_rd_resp: if (i_req.rready) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // read data captured at acceptance, zero when refused
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= !i_halt ? '0 : (is_reg ? i_dbg_reg_rdata : i_dbg_mem_rdata);
        end
    end

    assign o_rsp.awready = wr_fire;
    assign o_rsp.wready  = wr_fire;
    assign o_rsp.bvalid  = (state == st_wr_resp);
    assign o_rsp.bresp   = bresp_q;
    assign o_rsp.arready = (state == st_idle) && !(i_req.awvalid && i_req.wvalid);
    assign o_rsp.rvalid  = (state == st_rd_resp);
    assign o_rsp.rdata   = rdata_q;
    assign o_rsp.rresp   = rresp_q;

endmodule

//--- design/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_halt,
    input  mips_pkg::ex_mem_t   i_ex_mem,
    input  axil_pkg::axil_req_t i_dbg_req,
    output axil_pkg::axil_rsp_t o_dbg_rsp,
    output mips_pkg::mem_wb_t   o_mem_wb
);

    localparam int AW = $clog2(RAM_DEPTH);

    mips_pkg::mem_wb_t   mem_wb;
    logic [AW-1:0]       dbg_mem_addr;
    mips_pkg::word_t     dbg_mem_wdata;
    logic                dbg_mem_we;
    mips_pkg::word_t     dbg_mem_rdata;
    mips_pkg::reg_addr_t dbg_reg_addr;
    mips_pkg::word_t     dbg_reg_wdata;
    logic                dbg_reg_we;
    mips_pkg::word_t     dbg_reg_rdata;

    mem_stage #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_mem_stage (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_halt          (i_halt),
        .i_ex_mem        (i_ex_mem),
        .i_dbg_mem_addr  (dbg_mem_addr),
        .i_dbg_mem_wdata (dbg_mem_wdata),
        .i_dbg_mem_we    (dbg_mem_we),
        .o_dbg_mem_rdata (dbg_mem_rdata),
        .o_mem_wb        (mem_wb)
    );

    reg_file_wb u_reg_file_wb (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_halt          (i_halt),
        .i_mem_wb        (mem_wb),
        .i_dbg_reg_addr  (dbg_reg_addr),
        .i_dbg_reg_wdata (dbg_reg_wdata),
        .i_dbg_reg_we    (dbg_reg_we),
        .o_dbg_reg_rdata (dbg_reg_rdata)
    );

    axil_debug_port #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_axil_debug_port (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_halt          (i_halt),
        .i_req           (i_dbg_req),
        .o_rsp           (o_dbg_rsp),
        .o_dbg_mem_addr  (dbg_mem_addr),
        .o_dbg_mem_wdata (dbg_mem_wdata),
        .o_dbg_mem_we    (dbg_mem_we),
        .i_dbg_mem_rdata (dbg_mem_rdata),
        .o_dbg_reg_addr  (dbg_reg_addr),
        .o_dbg_reg_wdata (dbg_reg_wdata),
        .o_dbg_reg_we    (dbg_reg_we),
        .i_dbg_reg_rdata (dbg_reg_rdata)
    );

    assign o_mem_wb = mem_wb;  // observation copy of MEM/WB

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);  // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

//--- tb/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb;

    localparam int N_ROUNDS  = 4;
    localparam int N_OPS     = 256 + N_ROUNDS * 160 + 288;  // rough count of all operations
    localparam int MAX_CYCLE = N_OPS * 20 + 1000;

    logic                clk;
    logic                rst_n;
    logic                halt;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::mem_wb_t   mem_wb;
    mips_pkg::mem_wb_t   exp_wb;
    axil_pkg::axil_req_t req;
    axil_pkg::axil_rsp_t rsp;
    axil_pkg::axil_resp_t exp_bresp;
    axil_pkg::axil_resp_t exp_rresp;
    mips_pkg::word_t     exp_rdata;
    mips_pkg::word_t     ref_mem [256];
    mips_pkg::word_t     ref_regs [32];
    integer              seed = 32'hc8e03b64;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    mem_wb_top #(.RAM_DEPTH(256)) dut0 (
        .clk       (clk),
        .i_rst_n   (rst_n),
        .i_halt    (halt),
        .i_ex_mem  (ex_mem),
        .i_dbg_req (req),
        .o_dbg_rsp (rsp),
        .o_mem_wb  (mem_wb)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    a_wb: assert property (@(posedge clk) disable iff (!rst_n) mem_wb == exp_wb)
        else stop_on_error($sformatf("Fail o_mem_wb expected %h got %h",
            $sampled(exp_wb), $sampled(mem_wb)));
    a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.bvalid && req.bready) |-> rsp.bresp == exp_bresp)
        else stop_on_error($sformatf("Fail bresp expected %h got %h",
            $sampled(exp_bresp), $sampled(rsp.bresp)));
    a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rvalid && req.rready) |-> rsp.rresp == exp_rresp)
        else stop_on_error($sformatf("Fail rresp expected %h got %h",
            $sampled(exp_rresp), $sampled(rsp.rresp)));
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rvalid && req.rready) |-> rsp.rdata == exp_rdata)
        else stop_on_error($sformatf("Fail rdata expected %h got %h",
            $sampled(exp_rdata), $sampled(rsp.rdata)));
    // responses must wait for the master
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.bvalid && !req.bready) |=> rsp.bvalid)
        else stop_on_error("bvalid dropped before bready was seen");
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rvalid && !req.rready) |=> (rsp.rvalid && $stable(rsp.rdata)))
        else stop_on_error("rvalid or rdata changed before rready was seen");
    a_rst_quiet: assert property (@(posedge clk) !rst_n |-> (!rsp.bvalid && !rsp.rvalid))
        else stop_on_error("response valid raised during reset");
    // write address and data accepted together, never over a pending response
    a_aw_w: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.awready == rsp.wready) &&
        (!rsp.awready || (req.awvalid && req.wvalid && !rsp.bvalid)))
        else stop_on_error("awready and wready not raised together on a free write channel");
    a_ar: assert property (@(posedge clk) disable iff (!rst_n)
        !(rsp.arready && rsp.rvalid))
        else stop_on_error("arready raised while a read response was pending");

    function automatic int rnd(input int n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    // lane pick and extension of a loaded word
    function automatic mips_pkg::word_t load_value(input mips_pkg::word_t w, input logic [1:0] off,
                                                   input mips_pkg::mem_width_e wd, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        if (wd == mips_pkg::width_byte) begin
            load_value = {{24{sgn && b[7]}}, b};
        end else if (wd == mips_pkg::width_half) begin
            load_value = {{16{sgn && h[15]}}, h};
        end else begin
            load_value = w;
        end
    endfunction

    task automatic do_op(input logic random_op);
        mips_pkg::ex_mem_t op;
        mips_pkg::mem_wb_t nxt;
        int                kind;
        logic [1:0]        off;
        logic [7:0]        idx;
        op = '0;
        if (random_op) begin
            kind     = rnd(3);  // 0 store, 1 load, 2 alu only
            op.width = mips_pkg::mem_width_e'(rnd(3));
            idx      = 8'(rnd(256));
            off      = 2'(rnd(4));
            if (op.width == mips_pkg::width_half) off[0] = 1'b0;
            if (op.width == mips_pkg::width_word) off = 2'b00;
            op.result     = {22'($random(seed)), idx, off};
            op.store_data = $random(seed);
            op.reg2write  = 5'(rnd(32));
            op.sign       = rnd(2) == 1;
            op.mem_write  = kind == 0;
            op.mem_read   = kind == 1;
            op.mem2reg    = kind == 1;
            op.reg_write  = (kind != 0) && (rnd(4) != 0);
        end
        nxt.read_data  = load_value(ref_mem[op.result[9:2]], op.result[1:0], op.width, op.sign);
        nxt.alu_result = op.result;
        nxt.reg2write  = op.reg2write;
        nxt.mem2reg    = op.mem2reg;
        nxt.reg_write  = op.reg_write;
        if (!halt && op.mem_write) begin
            case (op.width)
                mips_pkg::width_byte: ref_mem[op.result[9:2]][8*op.result[1:0] +: 8] =
                    op.store_data[7:0];
                mips_pkg::width_half: ref_mem[op.result[9:2]][8*op.result[1:0] +: 16] =
                    op.store_data[15:0];
                default: ref_mem[op.result[9:2]] = op.store_data;
            endcase
        end
        if (!halt && exp_wb.reg_write && exp_wb.reg2write != 0)  // MEM/WB lands on this edge
            ref_regs[exp_wb.reg2write] = exp_wb.mem2reg ? exp_wb.read_data : exp_wb.alu_result;
        ex_mem = op;
        @(posedge clk);
        #1;
        if (!halt) begin
            exp_wb = nxt;
        end
    endtask

    // idle bundles until the last write-back has landed
    task automatic drain();
        halt = 1'b0;
        do_op(1'b0);
        do_op(1'b0);
    endtask

    task automatic axi_write(input axil_pkg::axil_addr_t a, input mips_pkg::word_t d,
                             input logic [3:0] s, input axil_pkg::axil_resp_t er);
        int delay;
        exp_bresp   = er;
        req.awaddr  = a;
        req.wdata   = d;
        req.wstrb   = s;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        do @(negedge clk); while (!rsp.awready);
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        delay = rnd(4);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        req.bready = 1'b1;
        do @(negedge clk); while (!rsp.bvalid);
        @(posedge clk);
        #1;
        req.bready = 1'b0;
    endtask

    task automatic axi_read(input axil_pkg::axil_addr_t a, input mips_pkg::word_t ed,
                            input axil_pkg::axil_resp_t er);
        int delay;
        exp_rdata   = ed;
        exp_rresp   = er;
        req.araddr  = a;
        req.arvalid = 1'b1;
        do @(negedge clk); while (!rsp.arready);
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        delay = rnd(4);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        req.rready = 1'b1;
        do @(negedge clk); while (!rsp.rvalid);
        @(posedge clk);
        #1;
        req.rready = 1'b0;
    endtask

    task automatic check_all(input int mem_reads);
        int i;
        for (int n = 0; n < 32; n++) begin
            axi_read(12'h800 + 12'(4 * n), ref_regs[n], axil_pkg::resp_okay);
        end
        for (int k = 0; k < mem_reads; k++) begin
            i = (mem_reads == 256) ? k : rnd(256);
            axi_read(12'(4 * i), ref_mem[i], axil_pkg::resp_okay);
        end
    endtask

    initial begin
        int              n;
        int              i;
        mips_pkg::word_t d;
        halt   = 1'b1;
        ex_mem = '0;
        req    = '0;
        exp_wb = '0;
        exp_bresp = axil_pkg::resp_okay;
        exp_rresp = axil_pkg::resp_okay;
        exp_rdata = '0;
        for (int k = 0; k < 32; k++) ref_regs[k] = '0;
        wait (rst_n);
        @(posedge clk);
        #1;
        for (int k = 0; k < 256; k++) begin  // known RAM image with a distinct word per address
            ref_mem[k] = (k * 32'h9e3779b1) ^ 32'h5a5a0000 ^ k;
            axi_write(12'(4 * k), ref_mem[k], 4'hf, axil_pkg::resp_okay);
        end
        for (int r = 0; r < N_ROUNDS; r++) begin
            halt = 1'b0;
            repeat (80) do_op(1'b1);
            halt = 1'b1;  // last write-back stays frozen in MEM/WB
            repeat (8) do_op(1'b1);  // frozen stage leaves the refs alone
            check_all(16);
            n = 1 + rnd(31);
            d = $random(seed);
            axi_write(12'h800 + 12'(4 * n), d, 4'hf, axil_pkg::resp_okay);
            ref_regs[n] = d;
            axi_read(12'h800 + 12'(4 * n), d, axil_pkg::resp_okay);
            i = rnd(256);
            d = $random(seed);
            axi_write(12'(4 * i), d, 4'hf, axil_pkg::resp_okay);
            ref_mem[i] = d;
            axi_read(12'(4 * i), d, axil_pkg::resp_okay);
            axi_write(12'(4 * i), ~d, 4'b0011, axil_pkg::resp_slverr);  // partial strobe
            axi_read(12'(4 * i), d, axil_pkg::resp_okay);
            axi_write(12'h800, d, 4'hf, axil_pkg::resp_okay);
            axi_read(12'h800, '0, axil_pkg::resp_okay);
            drain();
            axi_write(12'(4 * i), ~d, 4'hf, axil_pkg::resp_slverr);  // running pipeline
            axi_read(12'(4 * i), '0, axil_pkg::resp_slverr);
            axi_write(12'h800 + 12'(4 * n), ~d, 4'hf, axil_pkg::resp_slverr);
            axi_read(12'h800 + 12'(4 * n), '0, axil_pkg::resp_slverr);
        end
        halt = 1'b1;
        do_op(1'b0);
        check_all(256);
        $display("No errors");
        $finish;
    end

    initial begin
        repeat (MAX_CYCLE) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLE);
        $display("Errors found");
        $fatal(1);
    end

endmodule

//--- list.f
design/mips_pkg.sv
design/axil_pkg.sv
design/data_ram.sv
design/mem_access.sv
design/mem_stage.sv
design/reg_file_wb.sv
design/axil_debug_port.sv
design/mem_wb_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_wb.sv

//--- run.sh
#!/bin/sh
# build and run the mem/wb testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_wb -f list.f -o sim_mem_wb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_mem_wb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation returned an error, see sim.log"
    exit 1
fi

if grep -q "No errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
